// ==== flist.f ====
+incdir+common
common/decodePkg.sv
rtl/instrClassify.sv
decode/aluDecode.sv
decode/flowDecode.sv
rtl/ctrlRegister.sv
rtl/decodeTop.sv
bench/decode_props.sv
bench/tbDecode.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tbDecode
FILELIST  := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
FAIL_MSG  := Test failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tbDecode.sv ====
`include "isa_consts.svh"

module tbDecode;
	import decodePkg::*;

	// Reset, about 400 stimulus cycles and some margin
	localparam int TIMEOUT_CYCLES = 500;

	logic                  clk;
	logic                  rstN;
	logic                  inValid;
	logic [`INSTR_W-1:0]   instruction;
	logic [`FLAG_W-1:0]    flags;
	logic                  outValid;
	aluOpE                 aluOp;
	logic [`REG_SEL_W-1:0] readSel1;
	logic [`REG_SEL_W-1:0] readSel2;
	logic [`REG_SEL_W-1:0] destSel;
	logic [`REG_SEL_W-1:0] destSel2;
	logic                  writeEn1;
	logic                  writeEn2;
	logic [`DATA_W-1:0]    immediate;
	logic                  useImm;
	logic                  flagWrite;
	logic                  memRead;
	logic                  memWrite;
	logic                  branchTaken;
	logic [`DATA_W-1:0]    branchAddr;
	resultSrcE             resultSrc;
	int                    cycleCount = 0;

	decodeTop dut (.*);

	bind decodeTop decode_props uProps (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic issue(input logic [`INSTR_W-1:0] instr, input logic [`FLAG_W-1:0] fl);
		inValid     <= 1'b1;
		instruction <= instr;
		flags       <= fl;
		@(posedge clk);
	endtask

	// Payload keeps changing while inValid is low
	task automatic idle(input int n);
		repeat (n) begin
			inValid     <= 1'b0;
			instruction <= `INSTR_W'($urandom());
			flags       <= `FLAG_W'($urandom());
			@(posedge clk);
		end
	endtask

	function automatic logic [`INSTR_W-1:0] regInstr(input logic [3:0] op,
		input logic [3:0] dest, input logic [3:0] src);
		return {2'b00, 4'b0000, dest, op, src};
	endfunction

	function automatic logic [`INSTR_W-1:0] immInstr(input logic [3:0] op,
		input logic [3:0] dest, input logic [7:0] imm);
		return {2'b00, op, dest, imm};
	endfunction

	function automatic logic [`INSTR_W-1:0] jumpInstr(input logic [4:0] code,
		input logic [12:0] addr);
		return {code, addr};
	endfunction

	function automatic logic [`INSTR_W-1:0] stackInstr(input logic [3:0] code,
		input logic [3:0] r);
		return {code, r, 10'h2a5};
	endfunction

	function automatic logic [`INSTR_W-1:0] incDecInstr(input logic [5:0] code,
		input logic [3:0] r);
		return {code, r, 8'h3c};
	endfunction

	initial begin
		logic [3:0] destPick [4];
		logic [4:0] jumpCodes [9];
		int         errors;

		destPick  = '{4'd12, 4'd13, 4'd11, 4'd4};
		jumpCodes = '{J, JE, JNE, JL, JLE, JB, JBE, 5'b01111, 5'b10011};
		void'($urandom(32'h5145cf47));

		clk         = 1'b0;
		rstN        = 1'b0;
		inValid     = 1'b0;
		instruction = '0;
		flags       = '0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;

		// Register form, opcodes 0 and 1 are illegal
		for (int op = 0; op < 16; op++) begin
			issue(regInstr(4'(op), destPick[op % 4], 4'(op + 3)), 3'(op));
		end
		for (int op = 2; op < 16; op++) begin
			issue(immInstr(4'(op), destPick[op % 4], 8'(op * 37)), 3'(op + 1));
		end

		// Every jump, plus unused flow codes, against every flag value
		for (int code = 0; code < 9; code++) begin
			for (int f = 0; f < 8; f++) begin
				issue(jumpInstr(jumpCodes[code], 13'(code * 911 + f)), 3'(f));
			end
		end

		issue(stackInstr(PUSH, 4'd5), 3'd2);
		for (int i = 0; i < 4; i++) begin
			issue(stackInstr(POP, destPick[i]), 3'(i));
			issue(incDecInstr(INCR, destPick[i]), 3'(i + 4));
			issue(incDecInstr(DECR, destPick[i]), 3'(i + 1));
		end

		// Unused 11xx codes and the retired memory group
		issue(stackInstr(4'b1110, 4'd3), 3'd7);
		issue(incDecInstr(6'b111110, 4'd6), 3'd1);
		issue(incDecInstr(6'b111111, 4'd12), 3'd5);
		issue({2'b00, 4'b0001, 12'h345}, 3'd3);

		repeat (300) begin
			if ($urandom() % 4 == 0) begin
				idle(1);
			end else begin
				issue(`INSTR_W'($urandom()), `FLAG_W'($urandom()));
			end
		end

		// Gaps of growing length
		for (int g = 1; g <= 4; g++) begin
			issue(`INSTR_W'($urandom()), `FLAG_W'($urandom()));
			idle(g);
		end
		idle(4);

		errors = dut.uProps.errCount;
		$display("Summary: %0d assertion failures in %0d cycles", errors, cycleCount);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== bench/decode_props.sv ====
`include "isa_consts.svh"

module decode_props (
	input logic                  clk,
	input logic                  rstN,
	input logic                  inValid,
	input logic [`INSTR_W-1:0]   instruction,
	input logic [`FLAG_W-1:0]    flags,
	input logic                  outValid,
	input decodePkg::aluOpE      aluOp,
	input logic [`REG_SEL_W-1:0] readSel1,
	input logic [`REG_SEL_W-1:0] readSel2,
	input logic [`REG_SEL_W-1:0] destSel,
	input logic [`REG_SEL_W-1:0] destSel2,
	input logic                  writeEn1,
	input logic                  writeEn2,
	input logic [`DATA_W-1:0]    immediate,
	input logic                  useImm,
	input logic                  flagWrite,
	input logic                  memRead,
	input logic                  memWrite,
	input logic                  branchTaken,
	input logic [`DATA_W-1:0]    branchAddr,
	input decodePkg::resultSrcE  resultSrc
);
	import decodePkg::*;

	int   errCount = 0;
	logic primed = 1'b0;

	// Input history two deep like the DUT pipeline
	logic                p1Valid;
	logic                p2Valid;
	logic [`INSTR_W-1:0] p1Instr;
	logic [`INSTR_W-1:0] p2Instr;
	logic [`FLAG_W-1:0]  p1Flags;
	logic [`FLAG_W-1:0]  p2Flags;

	logic                  expWe1;
	logic                  expWe2;
	logic                  expFlag;
	logic                  expMemRd;
	logic                  expMemWr;
	logic                  expBranch;
	logic                  expUseImm;
	logic                  isAlu;
	logic                  isFlow;
	logic                  isPush;
	logic                  usesRead1;
	logic [`REG_SEL_W-1:0] expRead1;
	logic [`REG_SEL_W-1:0] expDest;
	logic [`REG_SEL_W-1:0] expDest2;
	aluOpE                 expAluOp;
	resultSrcE             expSrc;
	logic [`DATA_W-1:0]    expImm;
	logic [`DATA_W-1:0]    expAddr;
	logic [6:0]            expEn;
	logic [6:0]            actEn;
	logic [3:0]            grp;
	logic [`REG_SEL_W-1:0] dField;
	logic [`REG_SEL_W-1:0] sField;
	logic                  dBank2;
	logic                  sBank2;

	always_ff @(posedge clk) begin
		primed <= 1'b1;
		if (!rstN) begin
			p1Valid <= 1'b0;
			p2Valid <= 1'b0;
		end else begin
			p1Valid <= inValid;
			p2Valid <= p1Valid;
		end
		p1Instr <= instruction;
		p2Instr <= p1Instr;
		p1Flags <= flags;
		p2Flags <= p1Flags;
	end

	assign grp    = p2Instr[15:12];
	assign dField = p2Instr[11:8];
	assign sField = p2Instr[13:10];
	assign dBank2 = (dField == `BANK2_LO) || (dField == `SP_REG);
	assign sBank2 = (sField == `BANK2_LO) || (sField == `SP_REG);

	////////////////////////////////////////////////////////////////////////////
	// Expected control word from the decode rules
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		expWe1    = 1'b0;
		expWe2    = 1'b0;
		expFlag   = 1'b0;
		expMemRd  = 1'b0;
		expMemWr  = 1'b0;
		expBranch = 1'b0;
		expUseImm = 1'b0;
		isAlu     = 1'b0;
		isFlow    = 1'b0;
		isPush    = 1'b0;
		usesRead1 = 1'b0;
		expRead1  = dField;
		expSrc    = srcNone;
		expDest   = dField;
		expDest2  = dField;
		expAluOp  = aluOpE'(p2Instr[7:4]);
		expImm    = {8'h00, p2Instr[7:0]};
		expAddr   = {2'b00, p2Instr[13:0]};

		case (p2Instr[17:16])
			2'b00: begin
				// Group 0001 held the memory moves and is no longer decoded
				isAlu     = (grp != 4'b0001);
				usesRead1 = isAlu;
				if (grp > 4'b0001) begin
					expAluOp  = aluOpE'(grp);
					expUseImm = 1'b1;
				end
				if (isAlu) begin
					case (expAluOp)
						nopA, reserved: ;
						MUL: begin
							expWe1   = 1'b1;
							expWe2   = 1'b1;
							expFlag  = 1'b1;
							expDest  = `MUL_DEST1;
							expDest2 = `MUL_DEST2;
							expSrc   = srcAlu;
						end
						CMP, CMPR: expFlag = 1'b1;
						MOVR: begin
							expWe1 = !dBank2;
							expWe2 = dBank2;
							expSrc = srcOperand;
						end
						default: begin
							expFlag = 1'b1;
							expWe1  = !dBank2;
							expWe2  = dBank2;
							expSrc  = srcAlu;
						end
					endcase
				end
			end
			2'b01, 2'b10: begin
				isFlow = 1'b1;
				case (flowOpE'(p2Instr[17:13]))
					J:       expBranch = 1'b1;
					JE:      expBranch = p2Flags[0];
					JNE:     expBranch = !p2Flags[0];
					JL:      expBranch = p2Flags[1];
					JLE:     expBranch = p2Flags[1] || p2Flags[0];
					JB:      expBranch = p2Flags[2];
					JBE:     expBranch = p2Flags[2] || p2Flags[0];
					default: ;
				endcase
			end
			default: begin
				case (stackOpE'(p2Instr[17:14]))
					PUSH: begin
						isPush    = 1'b1;
						usesRead1 = 1'b1;
						expRead1  = sField;
						expMemWr  = 1'b1;
						expWe2    = 1'b1;
						expDest2  = `SP_REG;
						expSrc    = srcIncDec;
					end
					POP: begin
						usesRead1 = 1'b1;
						expRead1  = sField;
						if (!sBank2) begin
							expMemRd = 1'b1;
							expWe1   = 1'b1;
							expDest  = sField;
							expSrc   = srcMem;
						end
					end
					incDecGrp: begin
						usesRead1 = 1'b1;
						if (p2Instr[17:12] == INCR || p2Instr[17:12] == DECR) begin
							expWe1 = !dBank2;
							expWe2 = dBank2;
							expSrc = srcIncDec;
						end
					end
					default: ;
				endcase
			end
		endcase
	end

	assign expEn = {expWe1, expWe2, expFlag, expMemRd, expMemWr, expBranch, expUseImm};
	assign actEn = {writeEn1, writeEn2, flagWrite, memRead, memWrite, branchTaken, useImm};

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	aLatency: assert property (@(posedge clk) primed |-> outValid == p2Valid)
		else begin
			errCount++;
			$error("[ERROR] latency: outValid expected %0b actual %0b",
				$sampled(p2Valid), $sampled(outValid));
		end

	aIdleQuiet: assert property (@(posedge clk) primed && !outValid |-> actEn == '0)
		else begin
			errCount++;
			$error("[ERROR] idleQuiet: enables expected 0000000 actual %b", $sampled(actEn));
		end

	aEnables: assert property (@(posedge clk) primed && outValid |-> actEn == expEn)
		else begin
			errCount++;
			$error("[ERROR] enables: expected %b actual %b", $sampled(expEn), $sampled(actEn));
		end

	aDest1: assert property (@(posedge clk) primed && outValid && expWe1 |-> destSel == expDest)
		else begin
			errCount++;
			$error("[ERROR] destSel: expected %0d actual %0d",
				$sampled(expDest), $sampled(destSel));
		end

	aDest2: assert property (@(posedge clk)
		primed && outValid && expWe2 |-> destSel2 == expDest2)
		else begin
			errCount++;
			$error("[ERROR] destSel2: expected %0d actual %0d",
				$sampled(expDest2), $sampled(destSel2));
		end

	aReadSel1: assert property (@(posedge clk)
		primed && outValid && usesRead1 |-> readSel1 == expRead1)
		else begin
			errCount++;
			$error("[ERROR] readSel1: expected %0d actual %0d",
				$sampled(expRead1), $sampled(readSel1));
		end

	aAluOp: assert property (@(posedge clk) primed && outValid && isAlu |-> aluOp == expAluOp)
		else begin
			errCount++;
			$error("[ERROR] aluOp: expected %0d actual %0d",
				$sampled(expAluOp), $sampled(aluOp));
		end

	aImmediate: assert property (@(posedge clk)
		primed && outValid && expUseImm |-> immediate == expImm)
		else begin
			errCount++;
			$error("[ERROR] immediate: expected %h actual %h",
				$sampled(expImm), $sampled(immediate));
		end

	aBranchAddr: assert property (@(posedge clk)
		primed && outValid && isFlow |-> branchAddr == expAddr)
		else begin
			errCount++;
			$error("[ERROR] branchAddr: expected %h actual %h",
				$sampled(expAddr), $sampled(branchAddr));
		end

	aResultSrc: assert property (@(posedge clk)
		primed && outValid && (expWe1 || expWe2) |-> resultSrc == expSrc)
		else begin
			errCount++;
			$error("[ERROR] resultSrc: expected %0d actual %0d",
				$sampled(expSrc), $sampled(resultSrc));
		end

	aPushRead: assert property (@(posedge clk)
		primed && outValid && isPush |-> readSel2 == `SP_REG)
		else begin
			errCount++;
			$error("[ERROR] pushReadSel2: expected %0d actual %0d",
				`SP_REG, $sampled(readSel2));
		end

endmodule

// ==== rtl/decodeTop.sv ====
`include "isa_consts.svh"

module decodeTop (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  inValid,
	input  logic [`INSTR_W-1:0]   instruction,
	input  logic [`FLAG_W-1:0]    flags,
	output logic                  outValid,
	output decodePkg::aluOpE      aluOp,
	output logic [`REG_SEL_W-1:0] readSel1,
	output logic [`REG_SEL_W-1:0] readSel2,
	output logic [`REG_SEL_W-1:0] destSel,
	output logic [`REG_SEL_W-1:0] destSel2,
	output logic                  writeEn1,
	output logic                  writeEn2,
	output logic [`DATA_W-1:0]    immediate,
	output logic                  useImm,
	output logic                  flagWrite,
	output logic                  memRead,
	output logic                  memWrite,
	output logic                  branchTaken,
	output logic [`DATA_W-1:0]    branchAddr,
	output decodePkg::resultSrcE  resultSrc
);
	import decodePkg::*;

	// Stage one
	logic [`INSTR_W-1:0]   stInstr;
	logic [`FLAG_W-1:0]    stFlags;
	instClassE             stClass;
	logic                  stValid;

	// ALU side
	aluOpE                 aluOpCode;
	logic [`REG_SEL_W-1:0] aluReadSel1;
	logic [`REG_SEL_W-1:0] aluReadSel2;
	logic [`REG_SEL_W-1:0] aluDestSel;
	logic [`REG_SEL_W-1:0] aluDestSel2;
	logic                  aluWriteEn1;
	logic                  aluWriteEn2;
	logic [`DATA_W-1:0]    aluImmediate;
	logic                  aluUseImm;
	logic                  aluFlagWrite;
	resultSrcE             aluResultSrc;

	// Flow side
	logic [`REG_SEL_W-1:0] flowReadSel1;
	logic [`REG_SEL_W-1:0] flowReadSel2;
	logic [`REG_SEL_W-1:0] flowDestSel;
	logic [`REG_SEL_W-1:0] flowDestSel2;
	logic                  flowWriteEn1;
	logic                  flowWriteEn2;
	logic                  flowMemRead;
	logic                  flowMemWrite;
	logic                  flowBranchTaken;
	logic [`DATA_W-1:0]    flowBranchAddr;
	resultSrcE             flowResultSrc;

	instrClassify uClassify (.*);

	aluDecode uAluDecode (
		.stInstr   (stInstr),
		.stClass   (stClass),
		.aluOp     (aluOpCode),
		.readSel1  (aluReadSel1),
		.readSel2  (aluReadSel2),
		.destSel   (aluDestSel),
		.destSel2  (aluDestSel2),
		.writeEn1  (aluWriteEn1),
		.writeEn2  (aluWriteEn2),
		.immediate (aluImmediate),
		.useImm    (aluUseImm),
		.flagWrite (aluFlagWrite),
		.resultSrc (aluResultSrc)
	);

	flowDecode uFlowDecode (
		.stInstr     (stInstr),
		.stFlags     (stFlags),
		.stClass     (stClass),
		.readSel1    (flowReadSel1),
		.readSel2    (flowReadSel2),
		.destSel     (flowDestSel),
		.destSel2    (flowDestSel2),
		.writeEn1    (flowWriteEn1),
		.writeEn2    (flowWriteEn2),
		.memRead     (flowMemRead),
		.memWrite    (flowMemWrite),
		.branchTaken (flowBranchTaken),
		.branchAddr  (flowBranchAddr),
		.resultSrc   (flowResultSrc)
	);

	// Port names match the wires above and the top outputs
	ctrlRegister uCtrlRegister (.*);

endmodule

// ==== rtl/ctrlRegister.sv ====
`include "isa_consts.svh"

module ctrlRegister (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  stValid,
	input  decodePkg::instClassE  stClass,
	// From aluDecode
	input  decodePkg::aluOpE      aluOpCode,
	input  logic [`REG_SEL_W-1:0] aluReadSel1,
	input  logic [`REG_SEL_W-1:0] aluReadSel2,
	input  logic [`REG_SEL_W-1:0] aluDestSel,
	input  logic [`REG_SEL_W-1:0] aluDestSel2,
	input  logic                  aluWriteEn1,
	input  logic                  aluWriteEn2,
	input  logic [`DATA_W-1:0]    aluImmediate,
	input  logic                  aluUseImm,
	input  logic                  aluFlagWrite,
	input  decodePkg::resultSrcE  aluResultSrc,
	// From flowDecode
	input  logic [`REG_SEL_W-1:0] flowReadSel1,
	input  logic [`REG_SEL_W-1:0] flowReadSel2,
	input  logic [`REG_SEL_W-1:0] flowDestSel,
	input  logic [`REG_SEL_W-1:0] flowDestSel2,
	input  logic                  flowWriteEn1,
	input  logic                  flowWriteEn2,
	input  logic                  flowMemRead,
	input  logic                  flowMemWrite,
	input  logic                  flowBranchTaken,
	input  logic [`DATA_W-1:0]    flowBranchAddr,
	input  decodePkg::resultSrcE  flowResultSrc,
	// Control word
	output logic                  outValid,
	output decodePkg::aluOpE      aluOp,
	output logic [`REG_SEL_W-1:0] readSel1,
	output logic [`REG_SEL_W-1:0] readSel2,
	output logic [`REG_SEL_W-1:0] destSel,
	output logic [`REG_SEL_W-1:0] destSel2,
	output logic                  writeEn1,
	output logic                  writeEn2,
	output logic [`DATA_W-1:0]    immediate,
	output logic                  useImm,
	output logic                  flagWrite,
	output logic                  memRead,
	output logic                  memWrite,
	output logic                  branchTaken,
	output logic [`DATA_W-1:0]    branchAddr,
	output decodePkg::resultSrcE  resultSrc
);
	import decodePkg::*;

	logic aluSide;
	logic live;

	assign aluSide = (stClass == normalReg) || (stClass == memRegOp) || (stClass == normalImm);
	// Enables only pass for a valid, legal instruction
	assign live    = stValid && (stClass != illegal);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid    <= 1'b0;
			aluOp       <= nopA;
			readSel1    <= '0;
			readSel2    <= '0;
			destSel     <= '0;
			destSel2    <= '0;
			writeEn1    <= 1'b0;
			writeEn2    <= 1'b0;
			immediate   <= '0;
			useImm      <= 1'b0;
			flagWrite   <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			branchTaken <= 1'b0;
			branchAddr  <= '0;
			resultSrc   <= srcNone;
		end else begin
			outValid   <= stValid;
			branchAddr <= flowBranchAddr;
			if (aluSide) begin
				aluOp       <= aluOpCode;
				readSel1    <= aluReadSel1;
				readSel2    <= aluReadSel2;
				destSel     <= aluDestSel;
				destSel2    <= aluDestSel2;
				writeEn1    <= live && aluWriteEn1;
				writeEn2    <= live && aluWriteEn2;
				immediate   <= aluImmediate;
				useImm      <= live && aluUseImm;
				flagWrite   <= live && aluFlagWrite;
				memRead     <= 1'b0;
				memWrite    <= 1'b0;
				branchTaken <= 1'b0;
				resultSrc   <= aluResultSrc;
			end else begin
				aluOp       <= nopA;
				readSel1    <= flowReadSel1;
				readSel2    <= flowReadSel2;
				destSel     <= flowDestSel;
				destSel2    <= flowDestSel2;
				writeEn1    <= live && flowWriteEn1;
				writeEn2    <= live && flowWriteEn2;
				immediate   <= '0;
				useImm      <= 1'b0;
				flagWrite   <= 1'b0;
				memRead     <= live && flowMemRead;
				memWrite    <= live && flowMemWrite;
				branchTaken <= live && flowBranchTaken;
				resultSrc   <= flowResultSrc;
			end
		end
	end

endmodule

// ==== decode/flowDecode.sv ====
`include "isa_consts.svh"

module flowDecode (
	input  logic [`INSTR_W-1:0]     stInstr,
	input  logic [`FLAG_W-1:0]      stFlags,
	input  decodePkg::instClassE    stClass,
	output logic [`REG_SEL_W-1:0]   readSel1,
	output logic [`REG_SEL_W-1:0]   readSel2,
	output logic [`REG_SEL_W-1:0]   destSel,
	output logic [`REG_SEL_W-1:0]   destSel2,
	output logic                    writeEn1,
	output logic                    writeEn2,
	output logic                    memRead,
	output logic                    memWrite,
	output logic                    branchTaken,
	output logic [`DATA_W-1:0]      branchAddr,
	output decodePkg::resultSrcE    resultSrc
);
	import decodePkg::*;

	flowOpE                jumpCode;
	stackOpE               stackCode;
	incDecOpE              incDecCode;
	logic [`REG_SEL_W-1:0] stackReg;
	logic [`REG_SEL_W-1:0] incReg;
	logic                  low;
	logic                  negative;
	logic                  zero;
	logic                  condMet;
	logic                  incBank2;
	logic                  popRefused;

	assign jumpCode   = flowOpE'(stInstr[`FLOW_OP_HI:`FLOW_OP_LO]);
	assign stackCode  = stackOpE'(stInstr[`STK_OP_HI:`STK_OP_LO]);
	assign incDecCode = incDecOpE'(stInstr[`INCDEC_OP_HI:`INCDEC_OP_LO]);
	assign stackReg   = stInstr[`STK_REG_HI:`STK_REG_LO];
	assign incReg     = stInstr[`DEST_HI:`DEST_LO];

	assign low      = stFlags[`FLAG_LOW];
	assign negative = stFlags[`FLAG_NEG];
	assign zero     = stFlags[`FLAG_ZERO];

	assign incBank2   = (incReg == `BANK2_LO) || (incReg == `SP_REG);
	// Never pop into the stack pointer or its neighbour
	assign popRefused = (stackReg == `BANK2_LO) || (stackReg == `SP_REG);

	assign branchAddr = {{(`DATA_W-`JUMP_ADDR_W){1'b0}}, stInstr[`JUMP_ADDR_W-1:0]};

	////////////////////////////////////////////////////////////////////////////
	// Jump conditions
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (jumpCode)
			J:       condMet = 1'b1;
			JE:      condMet = zero;
			JNE:     condMet = !zero;
			JL:      condMet = negative;
			JLE:     condMet = negative || zero;
			JB:      condMet = low;
			JBE:     condMet = low || zero;
			default: condMet = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stack and increment decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		readSel1    = '0;
		readSel2    = '0;
		destSel     = '0;
		destSel2    = '0;
		writeEn1    = 1'b0;
		writeEn2    = 1'b0;
		memRead     = 1'b0;
		memWrite    = 1'b0;
		branchTaken = 1'b0;
		resultSrc   = srcNone;

		case (stClass)
			flow14: begin
				branchTaken = condMet;
			end
			stackOp: begin
				readSel1 = stackReg;
				readSel2 = `SP_REG;
				destSel  = stackReg;
				destSel2 = `SP_REG;
				if (stackCode == PUSH) begin
					memWrite  = 1'b1;
					writeEn2  = 1'b1;
					resultSrc = srcIncDec;
				end else if (stackCode == POP && !popRefused) begin
					memRead   = 1'b1;
					writeEn1  = 1'b1;
					resultSrc = srcMem;
				end
			end
			incDecOp: begin
				readSel1 = incReg;
				readSel2 = incReg;
				destSel  = incReg;
				destSel2 = incReg;
				if (incDecCode == INCR || incDecCode == DECR) begin
					writeEn1  = !incBank2;
					writeEn2  = incBank2;
					resultSrc = srcIncDec;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== decode/aluDecode.sv ====
`include "isa_consts.svh"

module aluDecode (
	input  logic [`INSTR_W-1:0]   stInstr,
	input  decodePkg::instClassE  stClass,
	output decodePkg::aluOpE      aluOp,
	output logic [`REG_SEL_W-1:0] readSel1,
	output logic [`REG_SEL_W-1:0] readSel2,
	output logic [`REG_SEL_W-1:0] destSel,
	output logic [`REG_SEL_W-1:0] destSel2,
	output logic                  writeEn1,
	output logic                  writeEn2,
	output logic [`DATA_W-1:0]    immediate,
	output logic                  useImm,
	output logic                  flagWrite,
	output decodePkg::resultSrcE  resultSrc
);
	import decodePkg::*;

	logic                  immForm;
	logic                  aluForm;
	logic                  bank2;
	logic [`REG_SEL_W-1:0] dest;
	aluOpE                 opField;

	assign immForm = (stClass == normalImm);
	assign aluForm = (stClass == normalReg) || immForm;
	assign dest    = stInstr[`DEST_HI:`DEST_LO];
	assign opField = immForm ? aluOpE'(stInstr[`IMM_OP_HI:`IMM_OP_LO])
	                         : aluOpE'(stInstr[`REG_OP_HI:`REG_OP_LO]);

	// Registers 12 and 13 sit behind the second write port
	assign bank2 = (dest == `BANK2_LO) || (dest == `SP_REG);

	always_comb begin
		aluOp     = opField;
		readSel1  = dest;
		readSel2  = immForm ? dest : stInstr[`SRC_HI:`SRC_LO];
		destSel   = dest;
		destSel2  = dest;
		writeEn1  = 1'b0;
		writeEn2  = 1'b0;
		flagWrite = 1'b0;
		resultSrc = srcNone;
		immediate = {{(`DATA_W-`IMM_W){1'b0}}, stInstr[`IMM_W-1:0]};
		useImm    = immForm;

		if (aluForm) begin
			case (opField)
				ADD, SUB, AND, OR, XOR, NOT, LSH, RSH, ARSH, FMUL: begin
					flagWrite = 1'b1;
					writeEn1  = !bank2;
					writeEn2  = bank2;
					resultSrc = srcAlu;
				end
				MUL: begin
					// Product spans 11 and 12
					destSel   = `MUL_DEST1;
					destSel2  = `MUL_DEST2;
					flagWrite = 1'b1;
					writeEn1  = 1'b1;
					writeEn2  = 1'b1;
					resultSrc = srcAlu;
				end
				CMP, CMPR: begin
					flagWrite = 1'b1;
				end
				MOVR: begin
					writeEn1  = !bank2;
					writeEn2  = bank2;
					resultSrc = srcOperand;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/instrClassify.sv ====
`include "isa_consts.svh"

module instrClassify (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inValid,
	input  logic [`INSTR_W-1:0]  instruction,
	input  logic [`FLAG_W-1:0]   flags,
	output logic [`INSTR_W-1:0]  stInstr,
	output logic [`FLAG_W-1:0]   stFlags,
	output decodePkg::instClassE stClass,
	output logic                 stValid
);
	import decodePkg::*;

	logic [1:0] topBits;
	logic [3:0] group;
	stackOpE    stackCode;
	instClassE  nextClass;

	assign topBits   = instruction[`CLASS_HI:`CLASS_LO];
	assign group     = instruction[`GROUP_HI:`GROUP_LO];
	assign stackCode = stackOpE'(instruction[`STK_OP_HI:`STK_OP_LO]);

	always_comb begin
		case (topBits)
			2'b00: begin
				// N-type, nibble picks register, memory or immediate form
				if (group == 4'b0000) begin
					nextClass = normalReg;
				end else if (group == 4'b0001) begin
					nextClass = memRegOp;
				end else begin
					nextClass = normalImm;
				end
			end
			2'b01,
			2'b10: begin
				nextClass = flow14;
			end
			default: begin
				case (stackCode)
					POP,
					PUSH:      nextClass = stackOp;
					incDecGrp: nextClass = incDecOp;
					default:   nextClass = illegal;
				endcase
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stValid <= 1'b0;
		end else begin
			stValid <= inValid;
		end
	end

	// Payload, qualified by stValid downstream
	always_ff @(posedge clk) begin
		stInstr <= instruction;
		stFlags <= flags;
		stClass <= nextClass;
	end

endmodule

// ==== common/decodePkg.sv ====
package decodePkg;

	typedef enum logic [2:0] {
		normalReg,
		memRegOp,
		normalImm,
		flow14,
		stackOp,
		incDecOp,
		illegal
	} instClassE;

	// Shared by the register form [7:4] and the immediate form [15:12]
	typedef enum logic [3:0] {
		nopA     = 4'd0,
		reserved = 4'd1,
		ADD      = 4'd2,
		SUB      = 4'd3,
		AND      = 4'd4,
		OR       = 4'd5,
		XOR      = 4'd6,
		NOT      = 4'd7,
		LSH      = 4'd8,
		RSH      = 4'd9,
		ARSH     = 4'd10,
		FMUL     = 4'd11,
		MUL      = 4'd12,
		CMP      = 4'd13,
		CMPR     = 4'd14,
		MOVR     = 4'd15
	} aluOpE;

	typedef enum logic [4:0] {
		J   = 5'b01000,
		JE  = 5'b01001,
		JNE = 5'b01010,
		JL  = 5'b01011,
		JLE = 5'b01100,
		JB  = 5'b01101,
		JBE = 5'b01110
	} flowOpE;

	typedef enum logic [3:0] {
		POP       = 4'b1100,
		PUSH      = 4'b1101,
		incDecGrp = 4'b1111
	} stackOpE;

	typedef enum logic [5:0] {
		INCR = 6'b111100,
		DECR = 6'b111101
	} incDecOpE;

	typedef enum logic [2:0] {
		srcAlu,
		srcOperand,
		srcImm,
		srcMem,
		srcIncDec,
		srcNone
	} resultSrcE;

endpackage

// ==== common/isa_consts.svh ====
`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// Word and field widths
`define INSTR_W       18
`define REG_SEL_W     4
`define DATA_W        16
`define FLAG_W        3
`define IMM_W         8
`define JUMP_ADDR_W   14

// Flag bit positions
`define FLAG_LOW      2
`define FLAG_NEG      1
`define FLAG_ZERO     0

// Top level class bits and the N-type group nibble
`define CLASS_HI      17
`define CLASS_LO      16
`define GROUP_HI      15
`define GROUP_LO      12

// Opcode fields
`define REG_OP_HI     7
`define REG_OP_LO     4
`define IMM_OP_HI     15
`define IMM_OP_LO     12
`define FLOW_OP_HI    17
`define FLOW_OP_LO    13
`define STK_OP_HI     17
`define STK_OP_LO     14
`define INCDEC_OP_HI  17
`define INCDEC_OP_LO  12

// Register fields
`define DEST_HI       11
`define DEST_LO       8
`define SRC_HI        3
`define SRC_LO        0
`define STK_REG_HI    13
`define STK_REG_LO    10

// Special registers
`define SP_REG        4'd13
`define BANK2_LO      4'd12
`define MUL_DEST1     4'd11
`define MUL_DEST2     4'd12

`endif
